// File: digitizer_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared widths, local bus address map and packed structs
// for the digitizer support block and its testbench
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package digitizer_pkg;

	// local bus
	localparam int lb_aw = 24;
	localparam int lb_dw = 32;

	// word addresses of the plain registers
	localparam logic [lb_aw-1:0] addr_periph_config = 24'd0;
	localparam logic [lb_aw-1:0] addr_bitslip       = 24'd1;
	localparam logic [lb_aw-1:0] addr_u15_spi       = 24'd2;
	localparam logic [lb_aw-1:0] addr_u18_spi       = 24'd3;
	localparam logic [lb_aw-1:0] addr_spi_ctl       = 24'd4;
	localparam logic [lb_aw-1:0] addr_reset_ctl     = 24'd5;
	localparam logic [lb_aw-1:0] addr_clk_status    = 24'd6;
	localparam logic [lb_aw-1:0] addr_sync_cset     = 24'd7;

	// idelay window, matched on lb_addr[23:4] so 0x70..0x7f
	localparam logic [lb_aw-5:0] idelay_base = 20'd7;
	localparam int idelay_lanes = 16;
	localparam int idelay_aw    = 4; // lane index width
	localparam int idelay_dw    = 5; // tap value width

	// sync divider widths and enable thresholds
	localparam int ad7794_cw   = 10;
	localparam int ad7794_minc = 256;
	localparam int tps_cw      = 6;
	localparam int tps_minc    = 32;

	typedef struct packed {
		logic [29:0] spare;
		logic        pdwn;   // bit 1, both adcs
		logic        pwr_en; // bit 0
	} periph_cfg_t;

	typedef struct packed {
		logic        start;
		logic        read;
		logic [15:0] data; // word bits 31:16
		logic [15:0] addr; // word bits 15:0
	} u15_spi_t;

	typedef struct packed {
		logic        start;
		logic        read;
		logic [23:0] data; // word bits 31:8
		logic [7:0]  addr; // word bits 7:0
	} u18_spi_t;

	// last member sits at register bit 0
	typedef struct packed {
		logic idelayctrl; // bit 6
		logic mmcm;
		logic u4;
		logic u3_iserdes;
		logic u2_iserdes;
		logic u3_clk;
		logic u2_clk;     // bit 0
	} reset_ctl_t;

	typedef struct packed {
		logic                 strobe;
		logic [idelay_aw-1:0] addr;
		logic [idelay_dw-1:0] data;
	} idelay_wr_t;

	typedef struct packed {
		logic [ad7794_cw-1:0] ad7794;   // register bits 9:0
		logic [tps_cw-1:0]    tps62210; // register bits 21:16
	} sync_cset_t;

endpackage

`default_nettype wire

// File: digitizer_regbank.sv
// ~~~~~~~~~~~~~~~~~~~~
// host register bank on the local bus
// write decode into config registers, idelay write bus,
// clk_status write strobe, registered read data
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module digitizer_regbank (
	input  wire logic                            lb_clk,
	input  wire logic                            rst_n,
	input  wire logic                            lb_strobe,
	input  wire logic                            lb_rd,
	input  wire logic [digitizer_pkg::lb_aw-1:0] lb_addr,
	input  wire logic [digitizer_pkg::lb_dw-1:0] lb_dout,
	input  wire logic [1:0]                      clk_status,
	input  wire logic [digitizer_pkg::idelay_dw-1:0] idelay_mirror,
	output logic [digitizer_pkg::lb_dw-1:0]      lb_din,
	output digitizer_pkg::periph_cfg_t           periph_cfg,
	output logic [15:0]                          bitslip,
	output digitizer_pkg::u15_spi_t              u15_spi,
	output digitizer_pkg::u18_spi_t              u18_spi,
	output digitizer_pkg::reset_ctl_t            reset_ctl,
	output digitizer_pkg::sync_cset_t            sync_cset,
	output digitizer_pkg::idelay_wr_t            idelay_wr,
	output logic [digitizer_pkg::idelay_aw-1:0]  mirror_sel,
	output logic                                 clk_status_we,
	output logic [1:0]                           clk_status_data
);

	logic wr_en;
	logic rd_en;
	logic in_idelay;
	logic [digitizer_pkg::lb_dw-1:0] rd_mux;
	digitizer_pkg::idelay_wr_t idelay_req; // first stage of the idelay write

	assign wr_en     = lb_strobe & ~lb_rd;
	assign rd_en     = lb_strobe & lb_rd;
	assign in_idelay = lb_addr[digitizer_pkg::lb_aw-1:4] == digitizer_pkg::idelay_base;

	// clk_status tracker sees the write in the bus cycle itself
	assign clk_status_we   = wr_en & (lb_addr == digitizer_pkg::addr_clk_status);
	assign clk_status_data = lb_dout[1:0];

	assign mirror_sel = lb_addr[digitizer_pkg::idelay_aw-1:0]; // lane for readback

	// config register writes, all levels held until rewritten
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			periph_cfg <= '0;
			bitslip    <= '0;
			u15_spi    <= '0;
			u18_spi    <= '0;
			reset_ctl  <= '0;
			sync_cset  <= '0;
		end else if (wr_en) begin
			case (lb_addr)
				digitizer_pkg::addr_periph_config: periph_cfg <= lb_dout;
				digitizer_pkg::addr_bitslip:       bitslip <= lb_dout[15:0];
				digitizer_pkg::addr_u15_spi: begin
					u15_spi.data <= lb_dout[31:16];
					u15_spi.addr <= lb_dout[15:0];
				end
				digitizer_pkg::addr_u18_spi: begin
					u18_spi.data <= lb_dout[31:8];
					u18_spi.addr <= lb_dout[7:0];
				end
				digitizer_pkg::addr_spi_ctl: begin
					u15_spi.start <= lb_dout[0];
					u15_spi.read  <= lb_dout[1];
					u18_spi.start <= lb_dout[2];
					u18_spi.read  <= lb_dout[3];
				end
				digitizer_pkg::addr_reset_ctl: reset_ctl <= lb_dout[6:0];
				digitizer_pkg::addr_sync_cset: begin
					sync_cset.ad7794   <= lb_dout[9:0];
					sync_cset.tps62210 <= lb_dout[21:16];
				end
				default: ; // clk_status and idelay handled elsewhere
			endcase
		end
	end

	// idelay write bus, two stages so the loader sees it after edge N+1
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			idelay_req <= '0;
			idelay_wr  <= '0;
		end else begin
			idelay_req.strobe <= wr_en & in_idelay;
			idelay_req.addr   <= lb_addr[digitizer_pkg::idelay_aw-1:0];
			idelay_req.data   <= lb_dout[digitizer_pkg::idelay_dw-1:0];
			idelay_wr         <= idelay_req;
		end
	end

	// readback mux, zero extended
	always_comb begin
		rd_mux = '0;
		if (in_idelay) begin
			rd_mux = {27'b0, idelay_mirror};
		end else begin
			case (lb_addr)
				digitizer_pkg::addr_periph_config: rd_mux = periph_cfg;
				digitizer_pkg::addr_bitslip:       rd_mux = {16'b0, bitslip};
				digitizer_pkg::addr_u15_spi:       rd_mux = {u15_spi.data, u15_spi.addr};
				digitizer_pkg::addr_u18_spi:       rd_mux = {u18_spi.data, u18_spi.addr};
				digitizer_pkg::addr_spi_ctl: rd_mux = {28'b0, u18_spi.read, u18_spi.start,
					u15_spi.read, u15_spi.start};
				digitizer_pkg::addr_reset_ctl:  rd_mux = {25'b0, reset_ctl};
				digitizer_pkg::addr_clk_status: rd_mux = {30'b0, clk_status};
				digitizer_pkg::addr_sync_cset: rd_mux = {10'b0, sync_cset.tps62210, 6'b0,
					sync_cset.ad7794};
				default: rd_mux = '0; // unmapped
			endcase
		end
	end

	// read data one cycle after the read strobe, held until next read
	always_ff @(posedge lb_clk) begin
		if (!rst_n) lb_din <= '0;
		else if (rd_en) lb_din <= rd_mux;
	end

endmodule

`default_nettype wire

// File: idelay_loader.sv
// ~~~~~~~~~~~~~~~~~~~~
// idelay write bus to per-lane load pulses
// two-cycle pulse on lane 15-addr with a held tap value,
// plus a 16 lane readback mirror
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module idelay_loader (
	input  wire logic                               lb_clk,
	input  wire logic                               rst_n,
	input  wire digitizer_pkg::idelay_wr_t          idelay_wr,
	input  wire logic [digitizer_pkg::idelay_aw-1:0] mirror_sel,
	output logic [digitizer_pkg::idelay_lanes-1:0]  idelay_ld,
	output logic [digitizer_pkg::idelay_dw-1:0]     idelay_value,
	output logic [digitizer_pkg::idelay_dw-1:0]     idelay_mirror
);

	logic [digitizer_pkg::idelay_aw-1:0] ld_addr; // captured lane address
	logic [1:0] sr;                               // strobe delay line
	logic [digitizer_pkg::idelay_dw-1:0] mirror [digitizer_pkg::idelay_lanes];

	// capture address and tap value on the strobe
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			sr           <= '0;
			ld_addr      <= '0;
			idelay_value <= '0;
		end else begin
			sr <= {sr[0], idelay_wr.strobe};
			if (idelay_wr.strobe) begin
				ld_addr      <= idelay_wr.addr;
				idelay_value <= idelay_wr.data; // held until next write
			end
		end
	end

	// load pulse lasts while either stage of sr is set
	// lanes are in reversed order vs the bus address
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			idelay_ld <= '0;
		end else begin
			for (int i = 0; i < digitizer_pkg::idelay_lanes; i++) begin
				idelay_ld[i] <= (|sr) && (ld_addr == digitizer_pkg::idelay_lanes - 1 - i);
			end
		end
	end

	// readback mirror, indexed by bus address
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < digitizer_pkg::idelay_lanes; i++) mirror[i] <= '0;
		end else if (idelay_wr.strobe) begin
			mirror[idelay_wr.addr] <= idelay_wr.data;
		end
	end

	assign idelay_mirror = mirror[mirror_sel]; // async read, regbank registers it

endmodule

`default_nettype wire

// File: clk_status_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~
// mmcm clock status, 0 reset / 1 set up / 2 verified
// host writes advance it, loss of lock drops it to 0
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module clk_status_tracker (
	input  wire logic       lb_clk,
	input  wire logic       rst_n,
	input  wire logic       we,
	input  wire logic [1:0] data,
	input  wire logic       mmcm_locked,
	output logic [1:0]      clk_status
);

	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			clk_status <= 2'd0;
		end else if (!mmcm_locked) begin
			clk_status <= 2'd0; // lost lock wins over any write
		end else if (we) begin
			if (data[1] && clk_status == 2'd1) clk_status <= 2'd2; // verified
			else if (data[0]) clk_status <= 2'd1;                  // set up
		end
	end

endmodule

`default_nettype wire

// File: sync_generate.sv
// ~~~~~~~~~~~~~~~~~~~~
// programmable square wave sync clock
// half period cset+1 cycles, held low while cset < minc
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module sync_generate #(
	parameter int cw   = 10, // counter width
	parameter int minc = 256 // smallest setting that runs
) (
	input  wire logic          lb_clk,
	input  wire logic          rst_n,
	input  wire logic [cw-1:0] cset,
	output logic               sync
);

	logic [cw-1:0] cnt;
	logic          run;

	assign run = cset >= minc; // below minc the output is parked

	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			cnt  <= '0;
			sync <= 1'b0;
		end else if (!run) begin
			cnt  <= '0;   // held clear
			sync <= 1'b0; // and low
		end else if (cnt == cset) begin
			cnt  <= '0;
			sync <= ~sync; // half period done
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: digitizer_config.sv
// ~~~~~~~~~~~~~~~~~~~~
// digitizer board support, host settable part
// local bus in, board control levels and sync clocks out
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module digitizer_config (
	input  wire logic                            lb_clk,
	input  wire logic                            rst_n,
	input  wire logic                            lb_strobe,
	input  wire logic                            lb_rd,
	input  wire logic [digitizer_pkg::lb_aw-1:0] lb_addr,
	input  wire logic [digitizer_pkg::lb_dw-1:0] lb_dout,
	input  wire logic                            mmcm_locked,
	output logic [digitizer_pkg::lb_dw-1:0]      lb_din,
	output logic                                 u2_pdwn,
	output logic                                 u3_pdwn,
	output logic                                 pwr_en,
	output logic [7:0]                           u2_bitslip,
	output logic [7:0]                           u3_bitslip,
	output digitizer_pkg::u15_spi_t              u15_spi,
	output digitizer_pkg::u18_spi_t              u18_spi,
	output digitizer_pkg::reset_ctl_t            reset_ctl,
	output logic [7:0]                           u2_idelay_ld,
	output logic [7:0]                           u3_idelay_ld,
	output logic [digitizer_pkg::idelay_dw-1:0]  idelay_value,
	output logic [1:0]                           clk_status,
	output logic                                 u18_clk_in, // ad7794 sync
	output logic                                 pwr_sync    // tps62210 sync
);

	digitizer_pkg::periph_cfg_t periph_cfg;
	digitizer_pkg::sync_cset_t  sync_cset;
	digitizer_pkg::idelay_wr_t  idelay_wr;
	logic [15:0] bitslip;
	logic [digitizer_pkg::idelay_aw-1:0] mirror_sel;
	logic [digitizer_pkg::idelay_dw-1:0] idelay_mirror;
	logic [digitizer_pkg::idelay_lanes-1:0] idelay_ld;
	logic clk_status_we;
	logic [1:0] clk_status_data;

	digitizer_regbank u_regbank (
		.lb_clk          (lb_clk),
		.rst_n           (rst_n),
		.lb_strobe       (lb_strobe),
		.lb_rd           (lb_rd),
		.lb_addr         (lb_addr),
		.lb_dout         (lb_dout),
		.clk_status      (clk_status),
		.idelay_mirror   (idelay_mirror),
		.lb_din          (lb_din),
		.periph_cfg      (periph_cfg),
		.bitslip         (bitslip),
		.u15_spi         (u15_spi),
		.u18_spi         (u18_spi),
		.reset_ctl       (reset_ctl),
		.sync_cset       (sync_cset),
		.idelay_wr       (idelay_wr),
		.mirror_sel      (mirror_sel),
		.clk_status_we   (clk_status_we),
		.clk_status_data (clk_status_data)
	);

	idelay_loader u_idelay_loader (
		.lb_clk        (lb_clk),
		.rst_n         (rst_n),
		.idelay_wr     (idelay_wr),
		.mirror_sel    (mirror_sel),
		.idelay_ld     (idelay_ld),
		.idelay_value  (idelay_value),
		.idelay_mirror (idelay_mirror)
	);

	clk_status_tracker u_clk_status (
		.lb_clk      (lb_clk),
		.rst_n       (rst_n),
		.we          (clk_status_we),
		.data        (clk_status_data),
		.mmcm_locked (mmcm_locked),
		.clk_status  (clk_status)
	);

	sync_generate #(
		.cw   (digitizer_pkg::ad7794_cw),
		.minc (digitizer_pkg::ad7794_minc)
	) sync_ad7794 (
		.lb_clk (lb_clk),
		.rst_n  (rst_n),
		.cset   (sync_cset.ad7794),
		.sync   (u18_clk_in)
	);

	sync_generate #(
		.cw   (digitizer_pkg::tps_cw),
		.minc (digitizer_pkg::tps_minc)
	) sync_tps62210 (
		.lb_clk (lb_clk),
		.rst_n  (rst_n),
		.cset   (sync_cset.tps62210),
		.sync   (pwr_sync)
	);

	assign u2_pdwn      = periph_cfg.pdwn; // one bit powers down both adcs
	assign u3_pdwn      = periph_cfg.pdwn;
	assign pwr_en       = periph_cfg.pwr_en;
	assign u2_bitslip   = bitslip[7:0];
	assign u3_bitslip   = bitslip[15:8];
	assign u2_idelay_ld = idelay_ld[7:0];  // lanes 7..0
	assign u3_idelay_ld = idelay_ld[15:8]; // lanes 15..8

endmodule

`default_nettype wire

// File: tb_digitizer_config.sv
// ~~~~~~~~~~~~~~~~~~~~
// directed testbench for digitizer_config
// local bus tasks, one task per behavior, counts at the end
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_digitizer_config;

	localparam int half_period  = 50;   // 100 ns clock
	localparam int drive_delay  = 1;    // inputs move just after the edge
	localparam int ld_timeout   = 8;    // cycles to wait for a load pulse
	localparam int sync_timeout = 2000; // cycles to wait for a sync toggle
	localparam int ad_run_cset  = 300;
	localparam int tps_run_cset = 40;

	logic lb_clk;
	logic rst_n;
	logic lb_strobe;
	logic lb_rd;
	logic [digitizer_pkg::lb_aw-1:0] lb_addr;
	logic [digitizer_pkg::lb_dw-1:0] lb_dout;
	logic mmcm_locked;
	logic [digitizer_pkg::lb_dw-1:0] lb_din;
	logic u2_pdwn;
	logic u3_pdwn;
	logic pwr_en;
	logic [7:0] u2_bitslip;
	logic [7:0] u3_bitslip;
	digitizer_pkg::u15_spi_t u15_spi;
	digitizer_pkg::u18_spi_t u18_spi;
	digitizer_pkg::reset_ctl_t reset_ctl;
	logic [7:0] u2_idelay_ld;
	logic [7:0] u3_idelay_ld;
	logic [digitizer_pkg::idelay_dw-1:0] idelay_value;
	logic [1:0] clk_status;
	logic u18_clk_in;
	logic pwr_sync;

	integer seed;
	int errors;
	int tests_run;
	int tests_failed;
	int test_errs_start; // error count when the current test began

	digitizer_config u_dut (
		.lb_clk       (lb_clk),
		.rst_n        (rst_n),
		.lb_strobe    (lb_strobe),
		.lb_rd        (lb_rd),
		.lb_addr      (lb_addr),
		.lb_dout      (lb_dout),
		.mmcm_locked  (mmcm_locked),
		.lb_din       (lb_din),
		.u2_pdwn      (u2_pdwn),
		.u3_pdwn      (u3_pdwn),
		.pwr_en       (pwr_en),
		.u2_bitslip   (u2_bitslip),
		.u3_bitslip   (u3_bitslip),
		.u15_spi      (u15_spi),
		.u18_spi      (u18_spi),
		.reset_ctl    (reset_ctl),
		.u2_idelay_ld (u2_idelay_ld),
		.u3_idelay_ld (u3_idelay_ld),
		.idelay_value (idelay_value),
		.clk_status   (clk_status),
		.u18_clk_in   (u18_clk_in),
		.pwr_sync     (pwr_sync)
	);

	initial begin
		lb_clk = 1'b0;
		forever #half_period lb_clk = ~lb_clk;
	end

	// one cycle, ending just past the next rising edge
	task automatic next_cycle;
		@(posedge lb_clk);
		#drive_delay;
	endtask

	// single cycle write, sampled at the next edge
	task automatic bus_write(input logic [23:0] addr, input logic [31:0] data);
		lb_strobe = 1'b1;
		lb_rd     = 1'b0;
		lb_addr   = addr;
		lb_dout   = data;
		next_cycle();
		lb_strobe = 1'b0;
	endtask

	// read strobe for one cycle, lb_din valid right after that edge
	task automatic bus_read(input logic [23:0] addr, output logic [31:0] data);
		lb_strobe = 1'b1;
		lb_rd     = 1'b1;
		lb_addr   = addr;
		next_cycle();
		lb_strobe = 1'b0;
		lb_rd     = 1'b0;
		data      = lb_din;
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic start_test;
		test_errs_start = errors;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		if (errors == test_errs_start) begin
			$display("%0t ns: pass %s", $time, name);
		end else begin
			tests_failed++;
			$display("Fail at %0t ns: test %s, %0d errors", $time, name, errors - test_errs_start);
		end
	endtask

	function automatic logic [15:0] ld_lanes;
		return {u3_idelay_ld, u2_idelay_ld}; // lane 15 at the top
	endfunction

	function automatic logic sync_level(input int sel);
		return (sel == 0) ? u18_clk_in : pwr_sync; // 0 ad7794, 1 tps62210
	endfunction

	// cycles spent at one sync level, bounded
	task automatic count_while(input int sel, input logic level, output int cycles);
		cycles = 0;
		while (sync_level(sel) == level && cycles < sync_timeout) begin
			next_cycle();
			cycles++;
		end
		if (cycles >= sync_timeout) begin
			$display("timeout at %0t ns: sync output %0d stuck at %0b", $time, sel, level);
			errors++;
		end
	endtask

	// skip to a rising edge, then time one full period
	task automatic measure_sync(input int sel, output int hi, output int lo);
		int skip;
		count_while(sel, 1'b1, skip);
		count_while(sel, 1'b0, skip); // now just after a rise
		count_while(sel, 1'b1, hi);
		count_while(sel, 1'b0, lo);
	endtask

	task automatic check_reset_state;
		logic [31:0] rd;
		start_test();
		check_eq("u2_pdwn", u2_pdwn, 0);
		check_eq("u3_pdwn", u3_pdwn, 0);
		check_eq("pwr_en", pwr_en, 0);
		check_eq("bitslip", {u3_bitslip, u2_bitslip}, 0);
		check_eq("u15_spi start/read", {u15_spi.start, u15_spi.read}, 0);
		check_eq("u15_spi data", u15_spi.data, 0);
		check_eq("u15_spi addr", u15_spi.addr, 0);
		check_eq("u18_spi start/read", {u18_spi.start, u18_spi.read}, 0);
		check_eq("u18_spi data", u18_spi.data, 0);
		check_eq("u18_spi addr", u18_spi.addr, 0);
		check_eq("reset_ctl", reset_ctl, 0);
		check_eq("idelay load lanes", ld_lanes(), 0);
		check_eq("idelay_value", idelay_value, 0);
		check_eq("clk_status", clk_status, 0);
		check_eq("sync outputs", {u18_clk_in, pwr_sync}, 0);
		for (int a = 0; a < 8; a++) begin // plain registers
			bus_read(a, rd);
			check_eq($sformatf("reset readback addr %0d", a), rd, 0);
		end
		for (int a = 0; a < 16; a++) begin // idelay window
			bus_read(24'h70 + a, rd);
			check_eq($sformatf("reset readback idelay %0d", a), rd, 0);
		end
		end_test("reset state");
	endtask

	task automatic check_register_mirrors;
		logic [31:0] d;
		logic [31:0] rd;
		start_test();
		d = $random(seed);
		bus_write(digitizer_pkg::addr_periph_config, d);
		check_eq("pwr_en", pwr_en, d[0]);
		check_eq("u2_pdwn", u2_pdwn, d[1]); // one bit, both adcs
		check_eq("u3_pdwn", u3_pdwn, d[1]);
		bus_read(digitizer_pkg::addr_periph_config, rd);
		check_eq("periph_config readback", rd, d);
		d = $random(seed);
		bus_write(digitizer_pkg::addr_bitslip, d);
		check_eq("u2_bitslip", u2_bitslip, d[7:0]);
		check_eq("u3_bitslip", u3_bitslip, d[15:8]);
		bus_read(digitizer_pkg::addr_bitslip, rd);
		check_eq("bitslip readback", rd, {16'b0, d[15:0]});
		d = $random(seed);
		bus_write(digitizer_pkg::addr_u15_spi, d);
		check_eq("u15_spi data", u15_spi.data, d[31:16]); // high half is data
		check_eq("u15_spi addr", u15_spi.addr, d[15:0]);
		bus_read(digitizer_pkg::addr_u15_spi, rd);
		check_eq("u15_spi readback", rd, d);
		d = $random(seed);
		bus_write(digitizer_pkg::addr_u18_spi, d);
		check_eq("u18_spi data", u18_spi.data, d[31:8]);
		check_eq("u18_spi addr", u18_spi.addr, d[7:0]); // 8 bit addr
		bus_read(digitizer_pkg::addr_u18_spi, rd);
		check_eq("u18_spi readback", rd, d);
		d = $random(seed);
		bus_write(digitizer_pkg::addr_spi_ctl, d);
		check_eq("u15 start", u15_spi.start, d[0]);
		check_eq("u15 read", u15_spi.read, d[1]);
		check_eq("u18 start", u18_spi.start, d[2]);
		check_eq("u18 read", u18_spi.read, d[3]);
		bus_read(digitizer_pkg::addr_spi_ctl, rd);
		check_eq("spi_ctl readback", rd, {28'b0, d[3:0]});
		d = $random(seed);
		bus_write(digitizer_pkg::addr_reset_ctl, d);
		check_eq("reset u2_clk", reset_ctl.u2_clk, d[0]);
		check_eq("reset u3_clk", reset_ctl.u3_clk, d[1]);
		check_eq("reset u2_iserdes", reset_ctl.u2_iserdes, d[2]);
		check_eq("reset u3_iserdes", reset_ctl.u3_iserdes, d[3]);
		check_eq("reset u4", reset_ctl.u4, d[4]);
		check_eq("reset mmcm", reset_ctl.mmcm, d[5]);
		check_eq("reset idelayctrl", reset_ctl.idelayctrl, d[6]);
		bus_read(digitizer_pkg::addr_reset_ctl, rd);
		check_eq("reset_ctl readback", rd, {25'b0, d[6:0]});
		end_test("register mirrors");
	endtask

	task automatic check_idelay_loading;
		logic [31:0] taps [16]; // what each lane should hold
		logic [31:0] rd;
		logic [15:0] lane_mask;
		int cyc;
		start_test();
		for (int a = 0; a < 16; a++) begin
			taps[a] = $random(seed) & 32'h1f;
			lane_mask = 16'h8000 >> a; // lane 15 - addr
			bus_write(24'h70 + a, taps[a]); // sampled at edge N
			cyc = 0;
			while (ld_lanes() == 16'h0 && cyc < ld_timeout) begin
				next_cycle();
				cyc++;
			end
			if (cyc >= ld_timeout) begin
				$display("timeout at %0t ns: no idelay load pulse for addr %0d", $time, a);
				errors++;
			end else begin
				check_eq("load pulse start edge", cyc, 3); // after edge N+3
				check_eq("load lanes first cycle", ld_lanes(), lane_mask);
				check_eq("idelay_value", idelay_value, taps[a]);
				next_cycle();
				check_eq("load lanes second cycle", ld_lanes(), lane_mask);
				next_cycle();
				check_eq("load lanes after pulse", ld_lanes(), 0);
			end
			bus_read(24'h70 + a, rd);
			check_eq($sformatf("idelay readback %0d", a), rd, taps[a]);
		end
		for (int a = 0; a < 16; a++) begin // earlier lanes kept their values
			bus_read(24'h70 + a, rd);
			check_eq($sformatf("idelay mirror %0d", a), rd, taps[a]);
		end
		end_test("idelay loading");
	endtask

	task automatic check_clk_status;
		logic [31:0] rd;
		start_test();
		bus_write(digitizer_pkg::addr_clk_status, 2);
		check_eq("verify from reset state", clk_status, 0); // needs set up first
		bus_write(digitizer_pkg::addr_clk_status, 1);
		check_eq("set up", clk_status, 1);
		bus_write(digitizer_pkg::addr_clk_status, 2);
		check_eq("verified", clk_status, 2);
		bus_read(digitizer_pkg::addr_clk_status, rd);
		check_eq("clk_status readback", rd, 2);
		mmcm_locked = 1'b0;
		bus_write(digitizer_pkg::addr_clk_status, 1); // write while unlocked
		check_eq("lock lost during write", clk_status, 0);
		mmcm_locked = 1'b1;
		next_cycle();
		check_eq("relocked stays reset", clk_status, 0);
		bus_write(digitizer_pkg::addr_clk_status, 1);
		check_eq("set up again", clk_status, 1);
		bus_write(digitizer_pkg::addr_clk_status, 3);
		check_eq("both bits from set up", clk_status, 2); // bit 1 wins
		end_test("clk_status protocol");
	endtask

	task automatic check_sync_generators;
		logic [31:0] rd;
		int hi;
		int lo;
		int high_seen;
		start_test();
		bus_write(digitizer_pkg::addr_sync_cset, {10'b0, 6'(tps_run_cset), 6'b0, 10'(ad_run_cset)});
		bus_read(digitizer_pkg::addr_sync_cset, rd);
		check_eq("sync_cset readback", rd, {10'b0, 6'(tps_run_cset), 6'b0, 10'(ad_run_cset)});
		measure_sync(0, hi, lo);
		check_eq("u18_clk_in high time", hi, ad_run_cset + 1);
		check_eq("u18_clk_in low time", lo, ad_run_cset + 1);
		measure_sync(1, hi, lo);
		check_eq("pwr_sync high time", hi, tps_run_cset + 1);
		check_eq("pwr_sync low time", lo, tps_run_cset + 1);
		// one below each minimum
		bus_write(digitizer_pkg::addr_sync_cset, {10'b0, 6'd31, 6'b0, 10'd255});
		next_cycle(); // output parks one edge after the register changes
		high_seen = 0;
		for (int i = 0; i < 1000; i++) begin
			if (u18_clk_in !== 1'b0 || pwr_sync !== 1'b0) high_seen++;
			next_cycle();
		end
		check_eq("cycles with a parked sync output high", high_seen, 0);
		end_test("sync generators");
	endtask

	initial begin
		seed            = 1;
		errors          = 0;
		tests_run       = 0;
		tests_failed    = 0;
		test_errs_start = 0;
		rst_n           = 1'b0;
		lb_strobe       = 1'b0;
		lb_rd           = 1'b0;
		lb_addr         = '0;
		lb_dout         = '0;
		mmcm_locked     = 1'b1;
		repeat (4) @(posedge lb_clk); // reset held 4 cycles
		#drive_delay;
		rst_n = 1'b1;
		check_reset_state();
		check_register_mirrors();
		check_idelay_loading();
		check_clk_status();
		check_sync_generators();
		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
digitizer_pkg.sv
digitizer_regbank.sv
idelay_loader.sv
clk_status_tracker.sv
sync_generate.sv
digitizer_config.sv
tb_digitizer_config.sv

// File: Makefile
# Verilator build and run for the digitizer support block
# make        build and run the testbench, fail unless the log shows a pass
# make lint   lint the RTL top level
# make clean  remove build products and the log

VERILATOR ?= verilator
TB_TOP    ?= tb_digitizer_config
RTL_TOP   ?= digitizer_config
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Finished with no errors

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) digitizer_pkg.sv \
		digitizer_regbank.sv idelay_loader.sv clk_status_tracker.sv \
		sync_generate.sv digitizer_config.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)
